// File: flist.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/tag_store.sv
rtl/victim_select.sv
rtl/data_array.sv
rtl/cache_controller.sv
rtl/cache_top.sv
testbench/mem_model.sv
testbench/tb_cache_top.sv

// File: rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word address split
`define CACHE_WORD_ADDR_BITS	16
`define CACHE_BLOCK_BITS		2		// 4 words per block
`define CACHE_SET_BITS			4		// 16 sets
`define CACHE_TAG_BITS			10		// what is left of the word address

// organization
`define CACHE_WAYS				4
`define CACHE_WAY_BITS			2
`define CACHE_SETS				(1 << `CACHE_SET_BITS)

// data array is indexed by way, set and word
`define CACHE_ARRAY_BITS		(`CACHE_WAY_BITS + `CACHE_SET_BITS + `CACHE_BLOCK_BITS)
`define CACHE_ARRAY_WORDS		(1 << `CACHE_ARRAY_BITS)	// 256 words

`define CACHE_DATA_BITS			32

`endif

// File: rtl/cache_controller.sv
`include "cache_cfg.svh"

module cache_controller
	import cache_pkg::*;
(
	input  logic							clock_i,
	input  logic							resetn_i,

	// core
	input  logic							core_req_i,
	input  core_req_t						core_req_data_i,
	output logic							core_done_o,
	output logic [`CACHE_DATA_BITS-1:0]		core_rdata_o,

	// memory command and word buffers
	input  logic							mem_ready_i,
	output mem_cmd_t						mem_cmd_o,
	input  logic							buffer_read_ready_i,
	input  logic [`CACHE_DATA_BITS-1:0]		buffer_data_i,
	output logic							buffer_read_ack_o,
	input  logic							buffer_write_ready_i,
	output logic [`CACHE_DATA_BITS-1:0]		buffer_wdata_o,
	output logic							buffer_write_ack_o,

	// performance
	output logic							flag_hit_o,
	output logic							flag_miss_o,
	output logic							flag_writeback_o,

	// tag store
	input  logic							hit_i,
	input  logic [`CACHE_WAY_BITS-1:0]		hit_way_i,
	input  logic							victim_dirty_i,
	input  logic [`CACHE_TAG_BITS-1:0]		victim_tag_i,
	output cache_addr_t						lookup_addr_o,
	output logic							fill_o,
	output logic [`CACHE_WAY_BITS-1:0]		fill_way_o,
	output logic [`CACHE_TAG_BITS-1:0]		fill_tag_o,
	output logic							dirty_set_o,
	output logic							dirty_clear_o,
	output logic [`CACHE_WAY_BITS-1:0]		way_o,

	// victim select
	input  logic [`CACHE_WAY_BITS-1:0]		victim_way_i,
	output logic							advance_o,

	// data array
	output logic							mem_we_o,
	output logic [`CACHE_ARRAY_BITS-1:0]	mem_addr_o,
	output logic [`CACHE_DATA_BITS-1:0]		mem_wdata_o,
	input  logic [`CACHE_DATA_BITS-1:0]		mem_rdata_i
);

	cache_state_e					state_q;
	core_req_t						req_q;			// request in flight
	logic [`CACHE_WAY_BITS-1:0]		way_q;			// victim way of the current miss
	logic [`CACHE_TAG_BITS-1:0]		wb_tag_q;		// tag of the line being evicted
	logic [`CACHE_BLOCK_BITS-1:0]	cnt_q;			// word counter
	logic							phase_q;		// writeback read data valid
	logic							retry_q;		// lookup after a fill
	logic							done_q;
	logic [`CACHE_DATA_BITS-1:0]	rdata_q;
	logic							rd_ack_q;
	logic							wr_ack_q;
	logic [`CACHE_DATA_BITS-1:0]	wdata_q;
	mem_cmd_t						cmd_q;
	logic							hit_q;
	logic							miss_q;
	logic							wb_q;

	logic							lookup_hit;
	logic							fill_take;
	logic							fill_done;
	logic							wb_push;
	logic							last_word;

	// per cycle events
	// --------------------
	assign last_word  = &cnt_q;
	assign lookup_hit = (state_q == st_lookup) && hit_i;
	assign fill_take  = (state_q == st_fill) && buffer_read_ready_i && !rd_ack_q;	// pop in flight
	assign fill_done  = fill_take && last_word;
	assign wb_push    = (state_q == st_writeback) && phase_q && buffer_write_ready_i;

	// tag store side
	assign lookup_addr_o = req_q.addr;
	assign fill_o        = fill_done;
	assign fill_way_o    = way_q;
	assign fill_tag_o    = req_q.addr.tag;
	assign dirty_set_o   = lookup_hit && req_q.write;
	assign dirty_clear_o = wb_push && last_word;
	assign advance_o     = fill_done;		// next fill of this set takes the next way

	// hit way on a hit, candidate victim on a miss, then the latched way
	assign way_o = (state_q == st_lookup) ? (hit_i ? hit_way_i : victim_way_i) : way_q;

	// data array side
	assign mem_we_o    = dirty_set_o || fill_take;
	assign mem_wdata_o = (state_q == st_fill) ? buffer_data_i : req_q.wdata;

	always_comb begin
		case (state_q)
			st_lookup: begin
				mem_addr_o = {hit_way_i, req_q.addr.set, req_q.addr.word};
			end
			st_writeback, st_fill: begin
				mem_addr_o = {way_q, req_q.addr.set, cnt_q};	// block streaming
			end
			default: begin
				mem_addr_o = {way_q, req_q.addr.set, req_q.addr.word};
			end
		endcase
	end

	// registered ports
	assign core_done_o        = done_q;
	assign core_rdata_o       = rdata_q;
	assign buffer_read_ack_o  = rd_ack_q;
	assign buffer_write_ack_o = wr_ack_q;
	assign buffer_wdata_o     = wdata_q;
	assign mem_cmd_o          = cmd_q;
	assign flag_hit_o         = hit_q;
	assign flag_miss_o        = miss_q;
	assign flag_writeback_o   = wb_q;

	// sequencer
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= st_idle;
			cnt_q       <= '0;
			phase_q     <= 1'b0;
			retry_q     <= 1'b0;
			done_q      <= 1'b1;		// ready straight out of reset
			rd_ack_q    <= 1'b0;
			wr_ack_q    <= 1'b0;
			cmd_q.req   <= 1'b0;
			cmd_q.block <= 1'b0;
			cmd_q.rw    <= 1'b0;
			hit_q       <= 1'b0;
			miss_q      <= 1'b0;
			wb_q        <= 1'b0;
		end else begin
			// strobes
			rd_ack_q  <= 1'b0;
			wr_ack_q  <= 1'b0;
			cmd_q.req <= 1'b0;
			hit_q     <= 1'b0;
			miss_q    <= 1'b0;
			wb_q      <= 1'b0;

			case (state_q)
				st_idle: begin
					if (core_req_i) begin
						req_q   <= core_req_data_i;
						done_q  <= 1'b0;		// stall the core
						state_q <= st_lookup;
					end
				end

				st_lookup: begin
					if (hit_i) begin
						hit_q   <= !retry_q;	// no second strobe for a refilled access
						state_q <= st_read_data;
					end else begin
						miss_q   <= 1'b1;
						way_q    <= victim_way_i;
						wb_tag_q <= victim_tag_i;
						if (victim_dirty_i) begin
							wb_q    <= 1'b1;
							state_q <= st_writeback;
						end else begin
							state_q <= st_fill_cmd;
						end
					end
				end

				st_read_data: begin
					if (!req_q.write) begin
						rdata_q <= mem_rdata_i;
					end
					retry_q <= 1'b0;
					done_q  <= 1'b1;
					state_q <= st_idle;
				end

				st_writeback: begin
					if (!phase_q) begin
						phase_q <= 1'b1;			// word addressed, data next cycle
					end else if (buffer_write_ready_i) begin
						wr_ack_q <= 1'b1;
						wdata_q  <= mem_rdata_i;
						phase_q  <= 1'b0;
						cnt_q    <= cnt_q + 1'b1;	// wraps to 0 after the last word
						if (last_word) begin
							state_q <= st_write_cmd;
						end
					end
				end

				st_write_cmd: begin
					if (mem_ready_i && !cmd_q.req) begin
						cmd_q.req   <= 1'b1;
						cmd_q.block <= 1'b1;
						cmd_q.rw    <= 1'b1;
						cmd_q.addr  <= {wb_tag_q, req_q.addr.set, {`CACHE_BLOCK_BITS{1'b0}}};
						state_q     <= st_fill_cmd;
					end
				end

				st_fill_cmd: begin
					// memory needs a cycle to drop ready after the write command
					if (mem_ready_i && !cmd_q.req) begin
						cmd_q.req   <= 1'b1;
						cmd_q.block <= 1'b1;
						cmd_q.rw    <= 1'b0;
						cmd_q.addr  <= {req_q.addr.tag, req_q.addr.set, {`CACHE_BLOCK_BITS{1'b0}}};
						state_q     <= st_fill;
					end
				end

				st_fill: begin
					if (fill_take) begin
						rd_ack_q <= 1'b1;
						cnt_q    <= cnt_q + 1'b1;
						if (last_word) begin
							retry_q <= 1'b1;		// tag installed, access hits now
							state_q <= st_lookup;
						end
					end
				end

				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// protocol checks
	// --------------------
	// the level must still be up while the strobe is out
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_read_ack_o |-> buffer_read_ready_i)
		else $error("cache_controller: read buffer popped while empty");

	assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_cmd_o.req |-> mem_ready_i)
		else $error("cache_controller: command issued while memory busy");

endmodule

// File: rtl/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

	// controller sequence
	// --------------------
	typedef enum logic [2:0] {
		st_idle,		// waiting for a core request
		st_lookup,		// tag compare, hit data access
		st_read_data,	// sync read of the data array
		st_writeback,	// dirty victim words into write buffer
		st_write_cmd,	// block write for the victim
		st_fill_cmd,	// block read for the missed line
		st_fill			// read buffer words into the way
	} cache_state_e;

	// word address as the cache sees it
	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0]		tag;
		logic [`CACHE_SET_BITS-1:0]		set;
		logic [`CACHE_BLOCK_BITS-1:0]	word;
	} cache_addr_t;

	typedef struct packed {
		logic							write;	// store when set
		cache_addr_t					addr;
		logic [`CACHE_DATA_BITS-1:0]	wdata;	// ignored on loads
	} core_req_t;

	typedef struct packed {
		logic								req;	// one cycle per command
		logic								block;	// whole block transfer
		logic								rw;		// high for memory write
		logic [`CACHE_WORD_ADDR_BITS-1:0]	addr;	// block start
	} mem_cmd_t;

endpackage

// File: rtl/cache_top.sv
`include "cache_cfg.svh"

module cache_top
	import cache_pkg::*;
(
	input  logic							clock_i,
	input  logic							resetn_i,
	input  logic							core_req_i,
	input  core_req_t						core_req_data_i,
	output logic							core_done_o,
	output logic [`CACHE_DATA_BITS-1:0]		core_rdata_o,
	input  logic							mem_ready_i,
	output mem_cmd_t						mem_cmd_o,
	input  logic							buffer_read_ready_i,
	input  logic [`CACHE_DATA_BITS-1:0]		buffer_data_i,
	output logic							buffer_read_ack_o,
	input  logic							buffer_write_ready_i,
	output logic [`CACHE_DATA_BITS-1:0]		buffer_wdata_o,
	output logic							buffer_write_ack_o,
	output logic							flag_hit_o,
	output logic							flag_miss_o,
	output logic							flag_writeback_o
);

	// controller <-> tag store
	cache_addr_t					lookup_addr;
	logic							hit;
	logic [`CACHE_WAY_BITS-1:0]		hit_way;
	logic							victim_dirty;
	logic [`CACHE_TAG_BITS-1:0]		victim_tag;
	logic							fill;
	logic [`CACHE_WAY_BITS-1:0]		fill_way;
	logic [`CACHE_TAG_BITS-1:0]		fill_tag;
	logic							dirty_set;
	logic							dirty_clear;
	logic [`CACHE_WAY_BITS-1:0]		way;

	// controller <-> victim select
	logic [`CACHE_WAY_BITS-1:0]		victim_way;
	logic							advance;

	// controller <-> data array
	logic							mem_we;
	logic [`CACHE_ARRAY_BITS-1:0]	mem_addr;
	logic [`CACHE_DATA_BITS-1:0]	mem_wdata;
	logic [`CACHE_DATA_BITS-1:0]	mem_rdata;

	cache_controller u_cache_controller (
		.clock_i				(clock_i),
		.resetn_i				(resetn_i),
		.core_req_i				(core_req_i),
		.core_req_data_i		(core_req_data_i),
		.core_done_o			(core_done_o),
		.core_rdata_o			(core_rdata_o),
		.mem_ready_i			(mem_ready_i),
		.mem_cmd_o				(mem_cmd_o),
		.buffer_read_ready_i	(buffer_read_ready_i),
		.buffer_data_i			(buffer_data_i),
		.buffer_read_ack_o		(buffer_read_ack_o),
		.buffer_write_ready_i	(buffer_write_ready_i),
		.buffer_wdata_o			(buffer_wdata_o),
		.buffer_write_ack_o		(buffer_write_ack_o),
		.flag_hit_o				(flag_hit_o),
		.flag_miss_o			(flag_miss_o),
		.flag_writeback_o		(flag_writeback_o),
		.hit_i					(hit),
		.hit_way_i				(hit_way),
		.victim_dirty_i			(victim_dirty),
		.victim_tag_i			(victim_tag),
		.lookup_addr_o			(lookup_addr),
		.fill_o					(fill),
		.fill_way_o				(fill_way),
		.fill_tag_o				(fill_tag),
		.dirty_set_o			(dirty_set),
		.dirty_clear_o			(dirty_clear),
		.way_o					(way),
		.victim_way_i			(victim_way),
		.advance_o				(advance),
		.mem_we_o				(mem_we),
		.mem_addr_o				(mem_addr),
		.mem_wdata_o			(mem_wdata),
		.mem_rdata_i			(mem_rdata)
	);

	tag_store u_tag_store (
		.clock_i		(clock_i),
		.resetn_i		(resetn_i),
		.lookup_addr_i	(lookup_addr),
		.fill_i			(fill),
		.fill_way_i		(fill_way),
		.fill_tag_i		(fill_tag),
		.dirty_set_i	(dirty_set),
		.dirty_clear_i	(dirty_clear),
		.way_i			(way),
		.hit_o			(hit),
		.hit_way_o		(hit_way),
		.victim_dirty_o	(victim_dirty),
		.victim_tag_o	(victim_tag)
	);

	victim_select u_victim_select (
		.clock_i	(clock_i),
		.resetn_i	(resetn_i),
		.set_i		(lookup_addr.set),	// set of the request in flight
		.advance_i	(advance),
		.way_o		(victim_way)
	);

	data_array u_data_array (
		.clock_i	(clock_i),
		.we_i		(mem_we),
		.addr_i		(mem_addr),
		.wdata_i	(mem_wdata),
		.rdata_o	(mem_rdata)
	);

endmodule

// File: rtl/data_array.sv
`include "cache_cfg.svh"

module data_array (
	input  logic							clock_i,
	input  logic							we_i,
	input  logic [`CACHE_ARRAY_BITS-1:0]	addr_i,		// {way, set, word}
	input  logic [`CACHE_DATA_BITS-1:0]		wdata_i,
	output logic [`CACHE_DATA_BITS-1:0]		rdata_o
);

	logic [`CACHE_DATA_BITS-1:0] mem_q [`CACHE_ARRAY_WORDS];

	// single port ram
	// --------------------
	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem_q[addr_i] <= wdata_i;
		end
		rdata_o <= mem_q[addr_i];	// old word on a write, one cycle latency
	end

endmodule

// File: rtl/tag_store.sv
`include "cache_cfg.svh"

module tag_store
	import cache_pkg::*;
(
	input  logic						clock_i,
	input  logic						resetn_i,
	input  cache_addr_t					lookup_addr_i,
	input  logic						fill_i,
	input  logic [`CACHE_WAY_BITS-1:0]	fill_way_i,
	input  logic [`CACHE_TAG_BITS-1:0]	fill_tag_i,
	input  logic						dirty_set_i,
	input  logic						dirty_clear_i,
	input  logic [`CACHE_WAY_BITS-1:0]	way_i,
	output logic						hit_o,
	output logic [`CACHE_WAY_BITS-1:0]	hit_way_o,
	output logic						victim_dirty_o,
	output logic [`CACHE_TAG_BITS-1:0]	victim_tag_o
);

	logic [`CACHE_TAG_BITS-1:0]	tag_q [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0]		valid_q [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0]		dirty_q [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0]		hit_vec;		// one bit per way
	logic [`CACHE_SET_BITS-1:0]	set;

	assign set = lookup_addr_i.set;		// fills and dirty updates use the same set

	// lookup
	// --------------------
	always_comb begin
		hit_vec   = '0;
		hit_way_o = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == lookup_addr_i.tag);
			if (hit_vec[w]) begin
				hit_way_o = w[`CACHE_WAY_BITS-1:0];
			end
		end
	end

	assign hit_o          = |hit_vec;
	assign victim_dirty_o = dirty_q[set][way_i];
	assign victim_tag_o   = tag_q[set][way_i];	// old tag for the writeback address

	// state bits
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else begin
			if (fill_i) begin
				valid_q[set][fill_way_i] <= 1'b1;
				dirty_q[set][fill_way_i] <= 1'b0;	// fresh line from memory
			end
			if (dirty_set_i) begin
				dirty_q[set][way_i] <= 1'b1;		// write hit
			end else if (dirty_clear_i) begin
				dirty_q[set][way_i] <= 1'b0;		// victim written back
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (fill_i) begin
			tag_q[set][fill_way_i] <= fill_tag_i;
		end
	end

	// a fill never installs a tag already present in its set
	assert property (@(posedge clock_i) disable iff (!resetn_i) $onehot0(hit_vec))
		else $error("tag_store: several ways hit in set %0d", set);

endmodule

// File: rtl/victim_select.sv
`include "cache_cfg.svh"

module victim_select (
	input  logic						clock_i,
	input  logic						resetn_i,
	input  logic [`CACHE_SET_BITS-1:0]	set_i,
	input  logic						advance_i,	// strobe at the end of a fill
	output logic [`CACHE_WAY_BITS-1:0]	way_o
);

	// one rolling pointer per set
	logic [`CACHE_WAY_BITS-1:0] ptr_q [`CACHE_SETS];

	assign way_o = ptr_q[set_i];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				ptr_q[s] <= '0;		// way 0 goes first
			end
		end else if (advance_i) begin
			ptr_q[set_i] <= ptr_q[set_i] + 1'b1;	// wraps 3 -> 0
		end
	end

	// round robin step
	// --------------------
	// the pointer only moves on a fill of its own set, so the next
	// victim of that set is always the way filled longest ago

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_cache_top -o sim_cache

./obj_dir/sim_cache > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1

// File: testbench/cache_testdata.txt
# op(R/W) addr wdata hit(H)/miss(M) rdata wb_block
# rdata checked on reads only, wb_block ffff means no writeback
R 0041 00000000 M c0de0041 ffff
R 0043 00000000 H c0de0043 ffff
W 0042 12345678 H 00000000 ffff
R 0042 00000000 H 12345678 ffff
R 0084 00000000 M c0de0084 ffff
R 00c5 00000000 M c0de00c5 ffff
R 0106 00000000 M c0de0106 ffff
R 0147 00000000 M c0de0147 ffff
R 0184 00000000 M c0de0184 ffff
R 00c4 00000000 H c0de00c4 ffff
R 0085 00000000 M c0de0085 ffff
R 0080 00000000 M c0de0080 ffff
R 00c0 00000000 M c0de00c0 ffff
R 0100 00000000 M c0de0100 ffff
R 0141 00000000 M c0de0141 0040
R 0042 00000000 M 12345678 ffff
R 0041 00000000 H c0de0041 ffff
W 0201 aabbccdd M 00000000 ffff
R 0201 00000000 H aabbccdd ffff
W 0203 55aa55aa H 00000000 ffff
R 0240 00000000 M c0de0240 ffff
R 0280 00000000 M c0de0280 ffff
R 02c0 00000000 M c0de02c0 ffff
R 0300 00000000 M c0de0300 0200
R 0203 00000000 M 55aa55aa ffff
R 0202 00000000 H c0de0202 ffff
R 0201 00000000 H aabbccdd ffff
R ffff 00000000 M c0deffff ffff
W fffc 0badf00d H 00000000 ffff
R fffc 00000000 H 0badf00d ffff

// File: testbench/mem_model.sv
`include "cache_cfg.svh"

module mem_model
	import cache_pkg::*;
(
	input  logic							clock_i,
	input  logic							resetn_i,
	input  mem_cmd_t						mem_cmd_i,
	output logic							mem_ready_o,
	output logic							buffer_read_ready_o,
	output logic [`CACHE_DATA_BITS-1:0]		buffer_data_o,
	input  logic							buffer_read_ack_i,
	output logic							buffer_write_ready_o,
	input  logic [`CACHE_DATA_BITS-1:0]		buffer_wdata_i,
	input  logic							buffer_write_ack_i
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH       = 1 << `CACHE_WORD_ADDR_BITS;	// whole word address space
	localparam int BLOCK_WORDS = 1 << `CACHE_BLOCK_BITS;

	logic [`CACHE_DATA_BITS-1:0]		mem [DEPTH];
	logic [`CACHE_DATA_BITS-1:0]		rd_fifo [$];	// fill words for the cache
	logic [`CACHE_DATA_BITS-1:0]		wr_fifo [$];	// writeback words before their command
	logic [`CACHE_WORD_ADDR_BITS-1:0]	word_addr;
	integer								seed = 32'h5ea7_49d3;
	int									busy = 0;		// cycles left with ready low
	logic								ready_q = 1'b1;
	logic								rd_ready_q = 1'b0;
	logic [`CACHE_DATA_BITS-1:0]		rd_data_q = '0;
	logic								wr_ready_q = 1'b1;

	assign mem_ready_o          = ready_q;
	assign buffer_read_ready_o  = rd_ready_q;
	assign buffer_data_o        = rd_data_q;
	assign buffer_write_ready_o = wr_ready_q;

	// sample at the edge, drive 1 ns later
	// --------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int a = 0; a < DEPTH; a++) begin
				mem[a[`CACHE_WORD_ADDR_BITS-1:0]] = {16'hc0de, a[15:0]};	// c0de + address
			end
			rd_fifo.delete();
			wr_fifo.delete();
			busy = 0;
		end else begin
			if (buffer_write_ack_i) begin
				wr_fifo.push_back(buffer_wdata_i);
			end
			if (buffer_read_ack_i && rd_fifo.size() > 0) begin
				void'(rd_fifo.pop_front());		// head word was taken
			end
			if (busy > 0) begin
				busy--;
			end
			if (mem_cmd_i.req) begin
				for (int w = 0; w < BLOCK_WORDS; w++) begin
					word_addr = mem_cmd_i.addr + w[`CACHE_WORD_ADDR_BITS-1:0];
					if (!mem_cmd_i.rw) begin
						rd_fifo.push_back(mem[word_addr]);
					end else if (wr_fifo.size() > 0) begin
						mem[word_addr] = wr_fifo.pop_front();
					end
				end
				busy = $random(seed) & 3;		// 0 to 3 busy cycles
			end
		end
		#1;
		ready_q    = (busy == 0);
		rd_ready_q = (rd_fifo.size() > 0) && (busy == 0);	// fill waits while busy too
		rd_data_q  = (rd_fifo.size() > 0) ? rd_fifo[0] : '0;
		wr_ready_q = (wr_fifo.size() < BLOCK_WORDS);
	end

endmodule

// File: testbench/tb_cache_top.sv
`include "cache_cfg.svh"

module tb_cache_top
	import cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 200;	// cycles per wait loop

	logic							clock = 1'b0;
	logic							resetn;
	logic							core_req;
	core_req_t						core_req_data;
	logic							core_done;
	logic [`CACHE_DATA_BITS-1:0]	core_rdata;
	logic							mem_ready;
	mem_cmd_t						mem_cmd;
	logic							buffer_read_ready;
	logic [`CACHE_DATA_BITS-1:0]	buffer_data;
	logic							buffer_read_ack;
	logic							buffer_write_ready;
	logic [`CACHE_DATA_BITS-1:0]	buffer_wdata;
	logic							buffer_write_ack;
	logic							flag_hit;
	logic							flag_miss;
	logic							flag_writeback;

	int								errors = 0;
	int								op_errors;		// failures of the current line
	int								tests = 0;
	bit								timed_out = 1'b0;
	int								n_hit;
	int								n_miss;
	int								n_wb;
	int								n_rd_cmd;
	int								n_wr_cmd;
	int								latency;		// cycles from acceptance to done
	logic [15:0]					rd_cmd_addr;
	logic [15:0]					wr_cmd_addr;

	always #5 clock = ~clock;

	cache_top u_cache_top (
		.clock_i(clock), .resetn_i(resetn),
		.core_req_i(core_req), .core_req_data_i(core_req_data),
		.core_done_o(core_done), .core_rdata_o(core_rdata),
		.mem_ready_i(mem_ready), .mem_cmd_o(mem_cmd),
		.buffer_read_ready_i(buffer_read_ready), .buffer_data_i(buffer_data),
		.buffer_read_ack_o(buffer_read_ack), .buffer_write_ready_i(buffer_write_ready),
		.buffer_wdata_o(buffer_wdata), .buffer_write_ack_o(buffer_write_ack),
		.flag_hit_o(flag_hit), .flag_miss_o(flag_miss), .flag_writeback_o(flag_writeback)
	);

	mem_model u_mem_model (
		.clock_i(clock), .resetn_i(resetn), .mem_cmd_i(mem_cmd), .mem_ready_o(mem_ready),
		.buffer_read_ready_o(buffer_read_ready), .buffer_data_o(buffer_data),
		.buffer_read_ack_i(buffer_read_ack), .buffer_write_ready_o(buffer_write_ready),
		.buffer_wdata_i(buffer_wdata), .buffer_write_ack_i(buffer_write_ack)
	);

	// helpers
	// --------------------
	task automatic next_cycle();
		@(posedge clock);
		#1;		// outputs settled, inputs driven here
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			op_errors++;
		end
	endtask

	task automatic record_events();
		n_hit  += flag_hit;
		n_miss += flag_miss;
		n_wb   += flag_writeback;
		if (mem_cmd.req) begin
			check_value("mem_cmd_o.block", 32'(mem_cmd.block), 32'd1);	// whole block moves
		end
		if (mem_cmd.req && mem_cmd.rw) begin
			n_wr_cmd++;
			wr_cmd_addr = mem_cmd.addr;
		end else if (mem_cmd.req) begin
			n_rd_cmd++;
			rd_cmd_addr = mem_cmd.addr;
		end
	endtask

	task automatic run_op(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
		input logic exp_hit, input logic [31:0] exp_rdata, input logic [15:0] exp_wb);
		int n;
		n = 0;
		while (!core_done && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!core_done) begin
			$display("timeout: the cache never became ready for a new request");
			timed_out = 1'b1;
			op_errors++;
			return;
		end
		n_hit    = 0;
		n_miss   = 0;
		n_wb     = 0;
		n_rd_cmd = 0;
		n_wr_cmd = 0;
		core_req_data.write = write;
		core_req_data.addr  = addr;
		core_req_data.wdata = wdata;
		core_req = 1'b1;
		next_cycle();		// acceptance edge
		core_req = 1'b0;
		latency = 0;
		while (!core_done && latency < WAIT_LIMIT) begin
			next_cycle();
			latency++;
			record_events();
		end
		if (!core_done) begin
			$display("timeout: the request never completed");
			timed_out = 1'b1;
			op_errors++;
			return;
		end
		if (exp_hit) begin
			check_value("flag_hit_o pulses", n_hit, 32'd1);
			check_value("flag_miss_o pulses", n_miss, 32'd0);
			check_value("hit latency", latency, 32'd2);		// lookup + data read
			check_value("mem_cmd_o requests", n_rd_cmd + n_wr_cmd, 32'd0);
		end else begin
			check_value("flag_hit_o pulses", n_hit, 32'd0);
			check_value("flag_miss_o pulses", n_miss, 32'd1);
			check_value("block read requests", n_rd_cmd, 32'd1);
			check_value("block read mem_cmd_o.addr", 32'(rd_cmd_addr), 32'(addr & ~16'h3));
		end
		if (exp_wb == 16'hffff) begin		// no eviction of a dirty line
			check_value("flag_writeback_o pulses", n_wb, 32'd0);
			check_value("block write requests", n_wr_cmd, 32'd0);
		end else begin
			check_value("flag_writeback_o pulses", n_wb, 32'd1);
			check_value("block write requests", n_wr_cmd, 32'd1);
			check_value("block write mem_cmd_o.addr", 32'(wr_cmd_addr), 32'(exp_wb));
		end
		if (!write) begin
			check_value("core_rdata_o", core_rdata, exp_rdata);
		end
	endtask

	// main sequence
	// --------------------
	initial begin
		int				fd;
		int				fields;
		int				line_no;
		string			line;
		byte			op_c;
		byte			hm_c;
		logic [15:0]	addr;
		logic [31:0]	wdata;
		logic [31:0]	exp_rdata;
		logic [15:0]	exp_wb;

		resetn        = 1'b0;
		core_req      = 1'b0;
		core_req_data = '0;
		repeat (3) next_cycle();		// reset for 3 cycles
		resetn = 1'b1;

		// idle state straight out of reset
		op_errors = 0;
		check_value("core_done_o", 32'(core_done), 32'd1);
		check_value("mem_cmd_o.req", 32'(mem_cmd.req), 32'd0);
		check_value("buffer_read_ack_o", 32'(buffer_read_ack), 32'd0);
		check_value("buffer_write_ack_o", 32'(buffer_write_ack), 32'd0);
		check_value("flags", 32'({flag_hit, flag_miss, flag_writeback}), 32'd0);
		tests++;
		errors += op_errors;
		$display("reset state: %s", (op_errors == 0) ? "ok" : "failed");

		fd = $fopen("testbench/cache_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/cache_testdata.txt");
			errors++;
		end else begin
			line_no = 0;
			while (!timed_out && $fgets(line, fd) != 0) begin
				line_no++;
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;		// blank or column notes
				end
				fields = $sscanf(line, "%c %h %h %c %h %h", op_c, addr, wdata, hm_c,
					exp_rdata, exp_wb);
				if (fields != 6) begin
					$display("line %0d of the data file could not be parsed", line_no);
					errors++;
					continue;
				end
				op_errors = 0;
				run_op(op_c == "W", addr, wdata, hm_c == "H", exp_rdata, exp_wb);
				tests++;
				errors += op_errors;
				$display("line %0d: %c %h %s", line_no, op_c, addr,
					(op_errors == 0) ? "ok" : "failed");
			end
			$fclose(fd);
		end

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
